/* Makefile */
# Verilator simulation of the instruction cache testbench

VERILATOR ?= verilator
TOP       ?= tb_icache
OBJ_DIR   ?= obj_dir
FILELIST  ?= list.f
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
PASS_TEXT ?= ALL TESTS PASSED

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

/* list.f */
src/icache_pkg.sv
src/line_store_if.sv
src/line_arrays.sv
src/line_store_arbiter.sv
src/lookup_ctrl.sv
src/refill_engine.sv
src/maint_engine.sv
src/icache_top.sv
testbench/tb_icache.sv

/* src/icache_pkg.sv */
package icache_pkg;

  ////////////////////
  // cache geometry
  ////////////////////

  localparam int unsigned ADDR_W         = 32;
  localparam int unsigned WORD_W         = 32;
  localparam int unsigned NUM_WAYS       = 2;
  localparam int unsigned NUM_SETS       = 16;
  localparam int unsigned WORDS_PER_LINE = 4;
  localparam int unsigned LINE_W         = WORD_W * WORDS_PER_LINE;
  localparam int unsigned OFFSET_W       = $clog2(LINE_W / 8);
  localparam int unsigned INDEX_W        = $clog2(NUM_SETS);
  localparam int unsigned TAG_W          = ADDR_W - INDEX_W - OFFSET_W;
  localparam int unsigned WAY_W          = $clog2(NUM_WAYS);
  // word select within a line and byte select within a word
  localparam int unsigned WOFF_W         = $clog2(WORDS_PER_LINE);
  localparam int unsigned BYTE_OFF_W     = $clog2(WORD_W / 8);

  // replacement lfsr, x^8 + x^6 + x^5 + x^4 + 1
  localparam int unsigned      LFSR_W    = 8;
  localparam logic [LFSR_W-1:0] LFSR_TAPS = 8'hB8;
  localparam logic [LFSR_W-1:0] LFSR_SEED = 8'hA5;

  // axi4-lite read constants
  localparam logic [2:0] AXI_PROT_INSTR = 3'b100;
  localparam logic [1:0] AXI_RESP_OKAY  = 2'b00;

  typedef logic [ADDR_W-1:0]   addr_t;
  typedef logic [TAG_W-1:0]    tag_t;
  typedef logic [INDEX_W-1:0]  index_t;
  typedef logic [LINE_W-1:0]   line_t;
  typedef logic [WORD_W-1:0]   word_t;
  typedef logic [NUM_WAYS-1:0] way_mask_t;

  typedef enum logic [1:0] {
    OP_READ,
    OP_WRITE,
    OP_CLEAR
  } store_op_e;

  ////////////////////
  // address fields
  ////////////////////

  function automatic tag_t addr_tag(addr_t addr);
    return addr[ADDR_W-1 -: TAG_W];
  endfunction

  function automatic index_t addr_index(addr_t addr);
    return addr[OFFSET_W +: INDEX_W];
  endfunction

  function automatic logic [WOFF_W-1:0] addr_woff(addr_t addr);
    return addr[BYTE_OFF_W +: WOFF_W];
  endfunction

endpackage

/* src/icache_top.sv */
module icache_top (
  input  logic               clk_i,
  input  logic               rst_ni,
  // fetch side
  input  logic               fetch_valid_i,
  input  icache_pkg::addr_t  fetch_addr_i,
  output logic               fetch_ready_o,
  output logic               rsp_valid_o,
  output icache_pkg::addr_t  rsp_addr_o,
  output icache_pkg::word_t  rsp_data_o,
  output logic               miss_o,
  // maintenance
  input  logic               flush_i,
  input  logic               inv_valid_i,
  input  icache_pkg::index_t inv_index_i,
  // axi4-lite read master
  output logic               m_arvalid_o,
  input  logic               m_arready_i,
  output icache_pkg::addr_t  m_araddr_o,
  output logic [2:0]         m_arprot_o,
  input  logic               m_rvalid_i,
  output logic               m_rready_o,
  input  icache_pkg::word_t  m_rdata_i,
  input  logic [1:0]         m_rresp_i
);
  import icache_pkg::*;

  logic  miss_valid;
  addr_t miss_addr;
  logic  fill_done;
  line_t fill_line;

  // one store port per requester
  line_store_if lookup_if ();
  line_store_if refill_if ();
  line_store_if maint_if ();

  lookup_ctrl u_lookup (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .fetch_valid_i (fetch_valid_i),
    .fetch_addr_i  (fetch_addr_i),
    .fetch_ready_o (fetch_ready_o),
    .rsp_valid_o   (rsp_valid_o),
    .rsp_addr_o    (rsp_addr_o),
    .rsp_data_o    (rsp_data_o),
    .miss_o        (miss_o),
    .miss_valid_o  (miss_valid),
    .miss_addr_o   (miss_addr),
    .fill_done_i   (fill_done),
    .fill_line_i   (fill_line),
    .port          (lookup_if.requester)
  );

  refill_engine u_refill (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .miss_valid_i (miss_valid),
    .miss_addr_i  (miss_addr),
    .fill_done_o  (fill_done),
    .fill_line_o  (fill_line),
    .m_arvalid_o  (m_arvalid_o),
    .m_arready_i  (m_arready_i),
    .m_araddr_o   (m_araddr_o),
    .m_arprot_o   (m_arprot_o),
    .m_rvalid_i   (m_rvalid_i),
    .m_rready_o   (m_rready_o),
    .m_rdata_i    (m_rdata_i),
    .m_rresp_i    (m_rresp_i),
    .port         (refill_if.requester)
  );

  maint_engine u_maint (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .flush_i     (flush_i),
    .inv_valid_i (inv_valid_i),
    .inv_index_i (inv_index_i),
    .port        (maint_if.requester)
  );

  line_store_arbiter u_arbiter (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .maint_port  (maint_if.arbiter),
    .refill_port (refill_if.arbiter),
    .lookup_port (lookup_if.arbiter)
  );

endmodule

/* src/line_arrays.sv */
module line_arrays (
  input  logic                                      clk_i,
  input  logic                                      rst_ni,
  input  icache_pkg::store_op_e                     op_i,
  input  logic                                      en_i,
  input  icache_pkg::index_t                        index_i,
  input  icache_pkg::way_mask_t                     way_mask_i,
  input  icache_pkg::tag_t                          wtag_i,
  input  icache_pkg::line_t                         wline_i,
  output icache_pkg::tag_t  [icache_pkg::NUM_WAYS-1:0] rtag_o,
  output icache_pkg::way_mask_t                     rvalid_o,
  output icache_pkg::line_t [icache_pkg::NUM_WAYS-1:0] rline_o
);
  import icache_pkg::*;

  // payload storage, one bank per way
  tag_t  tag_mem  [NUM_WAYS][NUM_SETS];
  line_t line_mem [NUM_WAYS][NUM_SETS];
  // valid bits kept in flops so reset clears them at once
  way_mask_t [NUM_SETS-1:0] valid_q;

  // tags and lines, written per masked way, read for all ways
  always_ff @(posedge clk_i) begin
    for (int w = 0; w < NUM_WAYS; w++) begin
      if (en_i && op_i == OP_WRITE && way_mask_i[w]) begin
        tag_mem[w][index_i]  <= wtag_i;
        line_mem[w][index_i] <= wline_i;
      end
      // read data stays put until the next granted read
      if (en_i && op_i == OP_READ) begin
        rtag_o[w]  <= tag_mem[w][index_i];
        rline_o[w] <= line_mem[w][index_i];
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q  <= '0;
      rvalid_o <= '0;
    end else if (en_i) begin
      unique case (op_i)
        OP_READ:  rvalid_o         <= valid_q[index_i];
        // a line write marks the written way valid
        OP_WRITE: valid_q[index_i] <= valid_q[index_i] | way_mask_i;
        // flush and invalidation drop the masked ways
        OP_CLEAR: valid_q[index_i] <= valid_q[index_i] & ~way_mask_i;
        default:  valid_q          <= valid_q;
      endcase
    end
  end

endmodule

/* src/line_store_arbiter.sv */
module line_store_arbiter (
  input logic   clk_i,
  input logic   rst_ni,
  line_store_if.arbiter maint_port,
  line_store_if.arbiter refill_port,
  line_store_if.arbiter lookup_port
);
  import icache_pkg::*;

  logic                 en;
  store_op_e            op;
  index_t               index;
  way_mask_t            way_mask;
  tag_t                 wtag;
  line_t                wline;
  tag_t  [NUM_WAYS-1:0] rtag;
  way_mask_t            rvalid;
  line_t [NUM_WAYS-1:0] rline;

  // fixed priority, maint over refill over lookup
  assign maint_port.gnt  = maint_port.req;
  assign refill_port.gnt = refill_port.req & ~maint_port.req;
  assign lookup_port.gnt = lookup_port.req & ~maint_port.req & ~refill_port.req;

  ////////////////////
  // request steering
  ////////////////////

  always_comb begin
    en       = lookup_port.req;
    op       = lookup_port.op;
    index    = lookup_port.index;
    way_mask = lookup_port.way_mask;
    wtag     = lookup_port.wtag;
    wline    = lookup_port.wline;
    if (maint_port.req) begin
      en       = 1'b1;
      op       = maint_port.op;
      index    = maint_port.index;
      way_mask = maint_port.way_mask;
      wtag     = maint_port.wtag;
      wline    = maint_port.wline;
    end else if (refill_port.req) begin
      en       = 1'b1;
      op       = refill_port.op;
      index    = refill_port.index;
      way_mask = refill_port.way_mask;
      wtag     = refill_port.wtag;
      wline    = refill_port.wline;
    end
  end

  line_arrays u_arrays (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .op_i       (op),
    .en_i       (en),
    .index_i    (index),
    .way_mask_i (way_mask),
    .wtag_i     (wtag),
    .wline_i    (wline),
    .rtag_o     (rtag),
    .rvalid_o   (rvalid),
    .rline_o    (rline)
  );

  // read data goes to every requester
  assign maint_port.rtag    = rtag;
  assign maint_port.rvalid  = rvalid;
  assign maint_port.rline   = rline;
  assign refill_port.rtag   = rtag;
  assign refill_port.rvalid = rvalid;
  assign refill_port.rline  = rline;
  assign lookup_port.rtag   = rtag;
  assign lookup_port.rvalid = rvalid;
  assign lookup_port.rline  = rline;

  // a refused line write keeps its set and victim way until served
  a_refill_held: assert property (@(posedge clk_i) disable iff (!rst_ni)
    refill_port.req && !refill_port.gnt |=>
      refill_port.req && $stable(refill_port.index) && $stable(refill_port.way_mask));

endmodule

/* src/line_store_if.sv */
interface line_store_if;
  import icache_pkg::*;

  // request side, held until gnt
  logic      req;
  store_op_e op;
  index_t    index;
  way_mask_t way_mask;
  tag_t      wtag;
  line_t     wline;

  // grant is combinational on req
  logic gnt;
  // read data of the last granted read, all ways, shared by every port
  tag_t  [NUM_WAYS-1:0] rtag;
  way_mask_t            rvalid;
  line_t [NUM_WAYS-1:0] rline;

  modport requester (
    output req, op, index, way_mask, wtag, wline,
    input  gnt, rtag, rvalid, rline
  );

  modport arbiter (
    input  req, op, index, way_mask, wtag, wline,
    output gnt, rtag, rvalid, rline
  );

endinterface

/* src/lookup_ctrl.sv */
module lookup_ctrl (
  input  logic                clk_i,
  input  logic                rst_ni,
  // core fetch side
  input  logic                fetch_valid_i,
  input  icache_pkg::addr_t   fetch_addr_i,
  output logic                fetch_ready_o,
  output logic                rsp_valid_o,
  output icache_pkg::addr_t   rsp_addr_o,
  output icache_pkg::word_t   rsp_data_o,
  output logic                miss_o,
  // miss handoff to the refill engine
  output logic                miss_valid_o,
  output icache_pkg::addr_t   miss_addr_o,
  input  logic                fill_done_i,
  input  icache_pkg::line_t   fill_line_i,
  line_store_if.requester     port
);
  import icache_pkg::*;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_COMPARE,
    ST_WAIT_FILL
  } state_e;

  state_e    state_q, state_d;
  addr_t     addr_q;
  logic      accept;
  way_mask_t hit_way;
  word_t     hit_word;
  word_t     fill_word;

  ////////////////////
  // set read
  ////////////////////

  // idle always reads the set of the address on offer
  assign port.req      = (state_q == ST_IDLE);
  assign port.op       = OP_READ;
  assign port.index    = addr_index(fetch_addr_i);
  assign port.way_mask = '1;
  assign port.wtag     = '0;
  assign port.wline    = '0;

  // no accept under reset or while maint or refill holds the arrays
  assign fetch_ready_o = rst_ni & (state_q == ST_IDLE) & port.gnt;
  assign accept        = fetch_valid_i & fetch_ready_o;

  // fetched address, kept for compare, miss and response
  always_ff @(posedge clk_i) begin
    if (accept) begin
      addr_q <= fetch_addr_i;
    end
  end

  ////////////////////
  // tag compare
  ////////////////////

  always_comb begin
    hit_way  = '0;
    hit_word = '0;
    for (int w = 0; w < NUM_WAYS; w++) begin
      if (port.rvalid[w] && port.rtag[w] == addr_tag(addr_q)) begin
        hit_way[w] = 1'b1;
        hit_word   = port.rline[w][addr_woff(addr_q) * WORD_W +: WORD_W];
      end
    end
  end

  assign fill_word = fill_line_i[addr_woff(addr_q) * WORD_W +: WORD_W];

  always_comb begin
    state_d     = state_q;
    rsp_valid_o = 1'b0;
    rsp_data_o  = hit_word;
    miss_o      = 1'b0;
    unique case (state_q)
      ST_IDLE: begin
        if (accept) begin
          state_d = ST_COMPARE;
        end
      end
      // read data of the accepted address is on the port now
      ST_COMPARE: begin
        if (|hit_way) begin
          rsp_valid_o = 1'b1;
          state_d     = ST_IDLE;
        end else begin
          miss_o  = 1'b1;
          state_d = ST_WAIT_FILL;
        end
      end
      // word comes straight from the refilled line
      ST_WAIT_FILL: begin
        rsp_data_o = fill_word;
        if (fill_done_i) begin
          rsp_valid_o = 1'b1;
          state_d     = ST_IDLE;
        end
      end
      default: state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= ST_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  assign rsp_addr_o   = addr_q;
  assign miss_valid_o = (state_q == ST_WAIT_FILL);
  assign miss_addr_o  = addr_q;

  // refill never installs a line twice, so a tag lives in one way only
  a_one_hit: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (state_q == ST_COMPARE) |-> $onehot0(hit_way));

endmodule

/* src/maint_engine.sv */
module maint_engine (
  input logic               clk_i,
  input logic               rst_ni,
  input logic               flush_i,
  input logic               inv_valid_i,
  input icache_pkg::index_t inv_index_i,
  line_store_if.requester   port
);
  import icache_pkg::*;

  localparam index_t LAST_SET = index_t'(NUM_SETS - 1);

  logic   flush_pend_q, flush_pend_d;
  logic   inv_pend_q, inv_pend_d;
  index_t inv_idx_q, inv_idx_d;
  // sweep position of a running flush
  index_t cnt_q, cnt_d;

  // clears hit both ways of one set per cycle
  assign port.req      = flush_pend_q | inv_pend_q;
  assign port.op       = OP_CLEAR;
  assign port.index    = flush_pend_q ? cnt_q : inv_idx_q;
  assign port.way_mask = '1;
  assign port.wtag     = '0;
  assign port.wline    = '0;

  always_comb begin
    flush_pend_d = flush_pend_q;
    inv_pend_d   = inv_pend_q;
    inv_idx_d    = inv_idx_q;
    cnt_d        = cnt_q;
    if (port.gnt) begin
      if (flush_pend_q) begin
        cnt_d = (cnt_q == LAST_SET) ? '0 : cnt_q + 1'b1;
        // sweep ends after the last set
        if (cnt_q == LAST_SET) begin
          flush_pend_d = 1'b0;
        end
      end else begin
        inv_pend_d = 1'b0;
      end
    end
    if (inv_valid_i) begin
      inv_pend_d = 1'b1;
      inv_idx_d  = inv_index_i;
    end
    if (flush_i) begin
      flush_pend_d = 1'b1;
    end
    // a flush covers any single-set invalidation
    if (flush_pend_d) begin
      inv_pend_d = 1'b0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      flush_pend_q <= 1'b0;
      inv_pend_q   <= 1'b0;
      inv_idx_q    <= '0;
      cnt_q        <= '0;
    end else begin
      flush_pend_q <= flush_pend_d;
      inv_pend_q   <= inv_pend_d;
      inv_idx_q    <= inv_idx_d;
      cnt_q        <= cnt_d;
    end
  end

  // once started, the sweep clears one set per cycle with no gap
  a_sweep_step: assert property (@(posedge clk_i) disable iff (!rst_ni)
    flush_pend_q && (cnt_q != LAST_SET) |=>
      flush_pend_q && (cnt_q == $past(cnt_q) + 1'b1));

endmodule

/* src/refill_engine.sv */
module refill_engine (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              miss_valid_i,
  input  icache_pkg::addr_t miss_addr_i,
  output logic              fill_done_o,
  output icache_pkg::line_t fill_line_o,
  // axi4-lite read master
  output logic              m_arvalid_o,
  input  logic              m_arready_i,
  output icache_pkg::addr_t m_araddr_o,
  output logic [2:0]        m_arprot_o,
  input  logic              m_rvalid_i,
  output logic              m_rready_o,
  input  icache_pkg::word_t m_rdata_i,
  input  logic [1:0]        m_rresp_i,
  line_store_if.requester   port
);
  import icache_pkg::*;

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_ADDR,
    ST_DATA,
    ST_WRITE,
    ST_DONE
  } state_e;

  state_e              state_q, state_d;
  logic [WOFF_W-1:0]   beat_q, beat_d;
  line_t               line_q;
  logic [LFSR_W-1:0]   lfsr_q;
  logic [WAY_W-1:0]    victim;
  logic                beat_done;
  logic                write_gnt;

  assign beat_done = m_rvalid_i & m_rready_o;
  assign write_gnt = port.req & port.gnt;

  ////////////////////
  // axi reads
  ////////////////////

  // one word per read, offsets 0, 4, 8, 12
  assign m_arvalid_o = (state_q == ST_ADDR);
  assign m_araddr_o  = {miss_addr_i[ADDR_W-1:OFFSET_W], beat_q, {BYTE_OFF_W{1'b0}}};
  assign m_arprot_o  = AXI_PROT_INSTR;
  assign m_rready_o  = (state_q == ST_DATA);

  always_comb begin
    state_d = state_q;
    beat_d  = beat_q;
    unique case (state_q)
      ST_IDLE: begin
        if (miss_valid_i) begin
          beat_d  = '0;
          state_d = ST_ADDR;
        end
      end
      ST_ADDR: begin
        if (m_arready_i) begin
          state_d = ST_DATA;
        end
      end
      ST_DATA: begin
        if (m_rvalid_i) begin
          beat_d  = beat_q + 1'b1;
          state_d = (&beat_q) ? ST_WRITE : ST_ADDR;
        end
      end
      ST_WRITE: begin
        if (port.gnt) begin
          state_d = ST_DONE;
        end
      end
      // fill_done pulse, lookup drops miss_valid on this edge
      ST_DONE: state_d = ST_IDLE;
      default: state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= ST_IDLE;
      beat_q  <= '0;
    end else begin
      state_q <= state_d;
      beat_q  <= beat_d;
    end
  end

  // line buffer, filled word by word
  always_ff @(posedge clk_i) begin
    if (beat_done) begin
      line_q[beat_q * WORD_W +: WORD_W] <= m_rdata_i;
    end
  end

  ////////////////////
  // victim choice
  ////////////////////

  // rvalid still holds the lookup read of this set
  always_comb begin
    victim = WAY_W'(lfsr_q[0]);
    for (int w = NUM_WAYS - 1; w >= 0; w--) begin
      if (!port.rvalid[w]) begin
        victim = WAY_W'(w);
      end
    end
  end

  // galois lfsr steps only on a random replacement
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      lfsr_q <= LFSR_SEED;
    end else if (write_gnt && (&port.rvalid)) begin
      lfsr_q <= (lfsr_q >> 1) ^ (lfsr_q[0] ? LFSR_TAPS : '0);
    end
  end

  assign port.req      = (state_q == ST_WRITE);
  assign port.op       = OP_WRITE;
  assign port.index    = addr_index(miss_addr_i);
  assign port.way_mask = way_mask_t'(1) << victim;
  assign port.wtag     = addr_tag(miss_addr_i);
  assign port.wline    = line_q;

  assign fill_done_o = (state_q == ST_DONE);
  assign fill_line_o = line_q;

  // address channel holds under a stalled arready
  a_ar_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    m_arvalid_o && !m_arready_i |=> m_arvalid_o && $stable(m_araddr_o));

  a_rresp_okay: assert property (@(posedge clk_i) disable iff (!rst_ni)
    beat_done |-> m_rresp_i == AXI_RESP_OKAY);

endmodule

/* testbench/tb_icache.sv */
module tb_icache;
  import icache_pkg::*;

  localparam int          NUM_FETCHES = 2000;
  localparam int          MAX_CYCLES  = NUM_FETCHES * 40;
  localparam int          RST_CYCLES  = 10;
  localparam int          NUM_LINES   = 64;
  localparam logic [31:0] LFSR_SEED   = 32'h7a95167b;
  // x^32 + x^22 + x^2 + x + 1, right-shifting form
  localparam logic [31:0] LFSR_POLY   = 32'h8020_0003;
  localparam addr_t       ADDR_BASE   = 32'h2000_0000;
  // unprivileged, secure, instruction access
  localparam logic [2:0]  FETCH_PROT  = 3'b100;

  // {tag select, set index} of one of the 64 lines in use
  typedef logic [5:0] line_sel_t;

  logic       clk_i;
  logic       rst_ni;
  logic       fetch_valid_i;
  addr_t      fetch_addr_i;
  logic       fetch_ready_o;
  logic       rsp_valid_o;
  addr_t      rsp_addr_o;
  word_t      rsp_data_o;
  logic       miss_o;
  logic       flush_i;
  logic       inv_valid_i;
  index_t     inv_index_i;
  logic       m_arvalid_o;
  logic       m_arready_i;
  addr_t      m_araddr_o;
  logic [2:0] m_arprot_o;
  logic       m_rvalid_i;
  logic       m_rready_o;
  word_t      m_rdata_i;
  logic [1:0] m_rresp_i;

  // stimulus state
  logic [31:0] lfsr_state;
  int          cycle_cnt;
  int          done_cnt;
  logic        accepted;
  logic        inflight;
  int          accept_cycle;
  logic        must_hit;
  logic        must_miss;
  logic        was_miss;
  addr_t       fetch_q[$];

  // reference model
  logic        cached [NUM_LINES];
  logic        last_valid;
  line_sel_t   last_line;

  // axi responder state
  int          reads_left;
  addr_t       read_base;
  logic        rd_pending;
  addr_t       rd_addr;
  logic        ar_stalled;
  addr_t       stall_addr;

  int          n_hits;
  int          n_misses;
  int          n_flush;
  int          n_inv;

  icache_top UUT (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .fetch_valid_i (fetch_valid_i),
    .fetch_addr_i  (fetch_addr_i),
    .fetch_ready_o (fetch_ready_o),
    .rsp_valid_o   (rsp_valid_o),
    .rsp_addr_o    (rsp_addr_o),
    .rsp_data_o    (rsp_data_o),
    .miss_o        (miss_o),
    .flush_i       (flush_i),
    .inv_valid_i   (inv_valid_i),
    .inv_index_i   (inv_index_i),
    .m_arvalid_o   (m_arvalid_o),
    .m_arready_i   (m_arready_i),
    .m_araddr_o    (m_araddr_o),
    .m_arprot_o    (m_arprot_o),
    .m_rvalid_i    (m_rvalid_i),
    .m_rready_o    (m_rready_o),
    .m_rdata_i     (m_rdata_i),
    .m_rresp_i     (m_rresp_i)
  );

  always begin
    #20 clk_i = ~clk_i;
  end

  ////////////////////
  // random bits
  ////////////////////

  // one lfsr step per bit handed out
  function automatic logic rand_bit();
    logic b;
    b = lfsr_state[0];
    lfsr_state = (lfsr_state >> 1) ^ (lfsr_state[0] ? LFSR_POLY : 32'h0);
    return b;
  endfunction

  function automatic logic [31:0] take_bits(int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], rand_bit()};
    end
    return v;
  endfunction

  // backing memory contents, mixed from the word address
  function automatic word_t mem_word(addr_t a);
    word_t x;
    x = {a[ADDR_W-1:2], 2'b00} ^ 32'h9e37_79b9;
    x = x ^ {x[15:0], x[31:16]};
    x = x * 32'h85eb_ca6b;
    return x ^ (x >> 13);
  endfunction

  function automatic addr_t line_base(addr_t a);
    return {a[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};
  endfunction

  function automatic line_sel_t line_of(addr_t a);
    return a[OFFSET_W +: 6];
  endfunction

  function automatic addr_t pick_addr();
    line_sel_t  sel;
    logic [1:0] woff;
    sel = line_sel_t'(take_bits(6));
    // about a quarter go back to the last line, for repeat hits
    if (last_valid && take_bits(2) == 0) begin
      sel = last_line;
    end
    woff = 2'(take_bits(2));
    return ADDR_BASE | (addr_t'(sel) << OFFSET_W) | (addr_t'(woff) << 2);
  endfunction

  ////////////////////
  // checks
  ////////////////////

  task automatic report_fail();
    $display("SOME TESTS FAILED");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic stop_with_error(string what);
    $display("ERROR at %0t: %s", $time, what);
    report_fail();
  endtask

  task automatic check_word(string name, word_t got, word_t exp);
    if (got !== exp) begin
      $display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp);
      report_fail();
    end
  endtask

  task automatic check_addr(string name, addr_t got, addr_t exp);
    if (got !== exp) begin
      $display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp);
      report_fail();
    end
  endtask

  task automatic check_flag(string name, logic got, logic exp);
    if (got !== exp) begin
      $display("MISMATCH at %0t: %s got %b expected %b", $time, name, got, exp);
      report_fail();
    end
  endtask

  task automatic check_prot(string name, logic [2:0] got, logic [2:0] exp);
    if (got !== exp) begin
      $display("MISMATCH at %0t: %s got %b expected %b", $time, name, got, exp);
      report_fail();
    end
  endtask

  ////////////////////
  // model updates
  ////////////////////

  task automatic apply_flush();
    for (int i = 0; i < NUM_LINES; i++) begin
      cached[i] = 1'b0;
    end
    last_valid = 1'b0;
    n_flush++;
  endtask

  // an invalidation drops all four tags of one set
  task automatic apply_inv(index_t idx);
    for (int t = 0; t < 4; t++) begin
      cached[{2'(t), idx}] = 1'b0;
    end
    if (last_line[3:0] == idx) begin
      last_valid = 1'b0;
    end
    n_inv++;
  endtask

  ////////////////////
  // monitors
  ////////////////////

  // read address channel, sampled before the edge updates
  task automatic watch_axi();
    if (ar_stalled) begin
      check_flag("m_arvalid_o", m_arvalid_o, 1'b1);
      check_addr("m_araddr_o", m_araddr_o, stall_addr);
    end
    if (m_rvalid_i && m_rready_o) begin
      rd_pending = 1'b0;
    end
    if (m_arvalid_o && m_arready_i) begin
      if (reads_left == 0 || rd_pending) begin
        stop_with_error("AXI read issued with no miss pending or a read still outstanding");
      end
      // beats go to base plus 0, 4, 8 and 12
      check_addr("m_araddr_o", m_araddr_o, read_base + addr_t'((4 - reads_left) * 4));
      check_prot("m_arprot_o", m_arprot_o, FETCH_PROT);
      reads_left--;
      rd_pending = 1'b1;
      rd_addr    = m_araddr_o;
    end
    ar_stalled = m_arvalid_o && !m_arready_i;
    stall_addr = m_araddr_o;
  endtask

  task automatic watch_fetch();
    addr_t exp;
    accepted = fetch_valid_i && fetch_ready_o;
    if (inflight && fetch_ready_o) begin
      stop_with_error("fetch_ready_o high while a fetch is in flight");
    end
    // compare cycle, exactly one of hit response and miss pulse
    if (inflight && cycle_cnt == accept_cycle + 1) begin
      check_flag("miss_o", miss_o, !rsp_valid_o);
      if (must_hit) begin
        check_flag("rsp_valid_o", rsp_valid_o, 1'b1);
      end
      if (must_miss) begin
        check_flag("miss_o", miss_o, 1'b1);
      end
      if (miss_o) begin
        was_miss   = 1'b1;
        reads_left = 4;
        read_base  = line_base(fetch_q[0]);
        n_misses++;
      end else begin
        n_hits++;
      end
    end else begin
      check_flag("miss_o", miss_o, 1'b0);
    end
    if (rsp_valid_o) begin
      if (!inflight || fetch_q.size() == 0) begin
        stop_with_error("response with no fetch in flight");
      end
      exp = fetch_q.pop_front();
      check_addr("rsp_addr_o", rsp_addr_o, exp);
      check_word("rsp_data_o", rsp_data_o, mem_word(rsp_addr_o));
      if (was_miss && reads_left != 0) begin
        stop_with_error("miss answered before all four AXI reads");
      end
      cached[line_of(exp)] = 1'b1;
      last_line  = line_of(exp);
      last_valid = 1'b1;
      inflight   = 1'b0;
      done_cnt++;
    end
    if (accepted) begin
      fetch_q.push_back(fetch_addr_i);
      inflight     = 1'b1;
      accept_cycle = cycle_cnt;
      was_miss     = 1'b0;
      must_hit     = last_valid && line_of(fetch_addr_i) == last_line;
      must_miss    = !cached[line_of(fetch_addr_i)];
    end
  endtask

  ////////////////////
  // drivers
  ////////////////////

  task automatic drive_axi();
    m_arready_i <= rand_bit();
    m_rresp_i   <= 2'b00;
    if (rd_pending) begin
      // rvalid holds once raised
      m_rvalid_i <= m_rvalid_i | rand_bit();
      m_rdata_i  <= mem_word(rd_addr);
    end else begin
      m_rvalid_i <= 1'b0;
    end
  endtask

  // maintenance only while no fetch is pending or in flight
  task automatic drive_fetch();
    logic [5:0] choice;
    index_t     idx;
    flush_i     <= 1'b0;
    inv_valid_i <= 1'b0;
    if (accepted) begin
      fetch_valid_i <= 1'b0;
    end else if (!fetch_valid_i && !inflight) begin
      choice = 6'(take_bits(6));
      if (choice == 0) begin
        flush_i <= 1'b1;
        apply_flush();
      end else if (choice < 4) begin
        idx = index_t'(take_bits(INDEX_W));
        inv_valid_i <= 1'b1;
        inv_index_i <= idx;
        apply_inv(idx);
      end else if (choice < 56) begin
        fetch_valid_i <= 1'b1;
        fetch_addr_i  <= pick_addr();
      end
    end
  endtask

  initial begin
    lfsr_state    = LFSR_SEED;
    clk_i         = 1'b0;
    rst_ni        = 1'b0;
    fetch_valid_i = 1'b0;
    fetch_addr_i  = '0;
    flush_i       = 1'b0;
    inv_valid_i   = 1'b0;
    inv_index_i   = '0;
    m_arready_i   = 1'b0;
    m_rvalid_i    = 1'b0;
    m_rdata_i     = '0;
    m_rresp_i     = 2'b00;
    cycle_cnt     = 0;
    done_cnt      = 0;
    accepted      = 1'b0;
    inflight      = 1'b0;
    last_valid    = 1'b0;
    reads_left    = 0;
    rd_pending    = 1'b0;
    ar_stalled    = 1'b0;
    for (int i = 0; i < NUM_LINES; i++) begin
      cached[i] = 1'b0;
    end
    repeat (RST_CYCLES) @(posedge clk_i);
    // outputs settle quiet under reset
    check_flag("fetch_ready_o", fetch_ready_o, 1'b0);
    check_flag("rsp_valid_o", rsp_valid_o, 1'b0);
    check_flag("miss_o", miss_o, 1'b0);
    check_flag("m_arvalid_o", m_arvalid_o, 1'b0);
    check_flag("m_rready_o", m_rready_o, 1'b0);
    rst_ni <= 1'b1;
    while (done_cnt < NUM_FETCHES) begin
      @(posedge clk_i);
      cycle_cnt++;
      if (cycle_cnt > MAX_CYCLES) begin
        stop_with_error("timeout, the fetch stream did not finish in time");
      end
      watch_axi();
      watch_fetch();
      drive_axi();
      drive_fetch();
    end
    $display("%0d fetches: %0d hits, %0d misses, %0d flushes, %0d invalidations",
             done_cnt, n_hits, n_misses, n_flush, n_inv);
    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule
